// File: filelist.f
design/merge_pkg.sv
design/beat_if.sv
design/run_tagger.sv
design/beat_presort.sv
design/stream_fifo.sv
design/channel_fifo_bank.sv
design/merge_frontend_top.sv
bench/tb_merge_frontend.sv

// File: Makefile
# Verilator flow for the merge sorter read-side front end

.PHONY: all lint clean

all: obj_dir/tb_merge_frontend
	./obj_dir/tb_merge_frontend | tee sim.log
	grep -qx "sim passed" sim.log

obj_dir/tb_merge_frontend: filelist.f design/*.sv bench/*.sv
	verilator --binary --timing --assert -j 0 --top-module tb_merge_frontend \
	  -f filelist.f -o tb_merge_frontend

lint:
	verilator --lint-only --top-module merge_frontend_top \
	  design/merge_pkg.sv design/beat_if.sv design/run_tagger.sv \
	  design/beat_presort.sv design/stream_fifo.sv \
	  design/channel_fifo_bank.sv design/merge_frontend_top.sv

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_merge_frontend.sv
/*
  Testbench for the merge front end with random read beats,
  per-channel reference queues and latency, run-mark and back-pressure checks
*/
`timescale 1ns/100ps

module tb_merge_frontend;

  localparam int PLANNED_BEATS  = 8 + 100 + 60 + 40;
  localparam int TIMEOUT_CYCLES = 2 * PLANNED_BEATS * 4 + 200;
  localparam logic [31:0] SEED  = 32'hcfceda28;

  typedef struct packed {
    logic             fast;      // Sent while its channel was idle
    logic             last;
    int               acc_edge;
    merge_pkg::beat_t data;      // Keys in ascending lane order
  } exp_beat_t;

  logic                                     aclk;
  logic                                     arst_n;
  logic                                     start;
  merge_pkg::run_cnt_t                      run_beats;
  logic                                     rvalid;
  logic                                     rready;
  merge_pkg::beat_t                         rdata;
  merge_pkg::ch_id_t                        rid;
  logic                                     rlast;
  logic [merge_pkg::NUM_CH-1:0]             out_tvalid;
  logic [merge_pkg::NUM_CH-1:0]             out_tready;
  merge_pkg::beat_t [merge_pkg::NUM_CH-1:0] out_tdata;
  logic [merge_pkg::NUM_CH-1:0]             out_tlast;

  exp_beat_t   exp_q [merge_pkg::NUM_CH][$];  // Beats accepted but not yet taken
  int          run_cnt [merge_pkg::NUM_CH];
  logic        shown [merge_pkg::NUM_CH];     // Head beat already seen at output
  logic [31:0] rnd;
  logic        ready_gaps;
  logic        hold_ch0;
  int          cyc;
  int          low_cycles;
  int          low_mark;
  int          other_taken;
  int          value_errors;
  int          other_errors;

  merge_frontend_top u_merge_frontend_top (.*);

  always #20 aclk = ~aclk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Plain bubble sort over the four lanes
  function automatic merge_pkg::beat_t sort_keys(input merge_pkg::beat_t beat);
    merge_pkg::key_t  k [merge_pkg::LANES];
    merge_pkg::key_t  tmp;
    merge_pkg::beat_t res;
    for (int i = 0; i < merge_pkg::LANES; i++) k[i] = beat[i*16 +: 16];
    for (int p = 0; p < merge_pkg::LANES - 1; p++) begin
      for (int j = 0; j < merge_pkg::LANES - 1; j++) begin
        if (k[j] > k[j+1]) begin
          tmp    = k[j];
          k[j]   = k[j+1];
          k[j+1] = tmp;
        end
      end
    end
    for (int i = 0; i < merge_pkg::LANES; i++) res[i*16 +: 16] = k[i];
    return res;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int c = 0; c < merge_pkg::NUM_CH; c++) n += exp_q[c].size();
    return n;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    value_errors++;
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic finish_run();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  ////////////////////
  // Stimulus helpers
  ////////////////////
  // One clock and new out_tready values 1 ns after the edge
  task automatic tick();
    @(posedge aclk);
    #1;
    rnd = xorshift(rnd);
    if (hold_ch0 && (low_cycles - low_mark >= 20)) hold_ch0 = 1'b0;  // Let channel 0 drain
    for (int c = 0; c < merge_pkg::NUM_CH; c++) begin
      if (c == 0 && hold_ch0) out_tready[c] = 1'b0;
      else if (ready_gaps) out_tready[c] = (rnd[2*c +: 2] != 2'b00);
      else out_tready[c] = 1'b1;
    end
  endtask

  task automatic send_beat(input merge_pkg::ch_id_t id, input logic last_in);
    logic taken;
    rnd = xorshift(rnd);
    rdata[31:0] = rnd;
    rnd = xorshift(rnd);
    rdata[63:32] = rnd;
    if (rnd[9:8] == 2'b00) rdata = rdata & {merge_pkg::LANES{16'h000f}};  // Equal keys
    rid    = id;
    rlast  = last_in;
    rvalid = 1'b1;
    taken  = 1'b0;
    while (!taken) begin
      @(negedge aclk);
      taken = rready;
      tick();
    end
    rvalid = 1'b0;
  endtask

  task automatic send_random(input int n);
    for (int i = 0; i < n; i++) begin
      rnd = xorshift(rnd);
      repeat (int'(rnd[1:0])) tick();
      send_beat(merge_pkg::ch_id_t'(rnd[3:2]), rnd[6:4] == 3'b000);
    end
  endtask

  task automatic restart_runs(input merge_pkg::run_cnt_t len);
    run_beats = len;
    start     = 1'b1;
    tick();
    start     = 1'b0;
  endtask

  task automatic wait_drain();
    while (pending() != 0) tick();
    repeat (3) tick();
  endtask

  ////////////////////
  // Reference model and output checks
  ////////////////////
  always @(negedge aclk) begin : monitor
    exp_beat_t ent;
    if (arst_n) begin
      if (!rready) low_cycles++;
      for (int c = 0; c < merge_pkg::NUM_CH; c++) begin
        if (out_tvalid[c] && exp_q[c].size() == 0) begin
          other_errors++;
          $display("ERROR at %0t: channel %0d shows a beat that was never sent", $time, c);
        end else if (out_tvalid[c]) begin
          ent = exp_q[c][0];
          if (!shown[c] && ent.fast) begin
            assert (cyc + 1 - ent.acc_edge == 5)
              else report_mismatch("out_tvalid latency", 64'(cyc + 1 - ent.acc_edge), 64'd5);
          end
          shown[c] = 1'b1;
          assert (out_tdata[c] == ent.data)
            else report_mismatch($sformatf("out_tdata[%0d]", c), out_tdata[c], ent.data);
          assert (out_tlast[c] == ent.last)
            else report_mismatch($sformatf("out_tlast[%0d]", c), 64'(out_tlast[c]),
                                 64'(ent.last));
          if (out_tready[c]) begin
            void'(exp_q[c].pop_front());
            shown[c] = 1'b0;
            if (hold_ch0 && c != 0) other_taken++;
          end
        end
      end
      if (start) begin
        for (int c = 0; c < merge_pkg::NUM_CH; c++) run_cnt[c] = 0;
      end
      if (rvalid && rready) begin
        run_cnt[rid] = run_cnt[rid] + 1;
        ent.last = rlast;
        if (run_beats != '0 && run_cnt[rid] == int'(run_beats)) begin
          ent.last     = 1'b1;  // Every run_beats-th beat closes a run
          run_cnt[rid] = 0;
        end
        ent.data     = sort_keys(rdata);
        ent.acc_edge = cyc + 1;
        ent.fast     = (exp_q[rid].size() == 0);
        exp_q[rid].push_back(ent);
        assert (exp_q[rid].size() <= merge_pkg::FIFO_DEPTH) else begin
          other_errors++;
          $display("ERROR at %0t: channel %0d has more than %0d beats outstanding",
                   $time, rid, merge_pkg::FIFO_DEPTH);
        end
      end
    end
  end

  // A stalled stream keeps its beat in place
  for (genvar c = 0; c < merge_pkg::NUM_CH; c++) begin : g_hold
    hold_check: assert property (@(posedge aclk) disable iff (!arst_n)
      (out_tvalid[c] && !out_tready[c]) |=>
        (out_tvalid[c] && $stable(out_tdata[c]) && $stable(out_tlast[c])))
      else begin
        other_errors++;
        $display("ERROR at %0t: channel %0d dropped or changed a stalled beat", $time, c);
      end
  end

  always @(posedge aclk) begin
    cyc++;
    if (cyc >= TIMEOUT_CYCLES) begin
      other_errors++;
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      finish_run();
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin
    aclk       = 1'b0;
    arst_n     = 1'b0;
    start      = 1'b0;
    run_beats  = '0;
    rvalid     = 1'b0;
    rdata      = '0;
    rid        = '0;
    rlast      = 1'b0;
    out_tready = '1;
    ready_gaps = 1'b0;
    hold_ch0   = 1'b0;
    rnd        = SEED;
    for (int c = 0; c < merge_pkg::NUM_CH; c++) shown[c] = 1'b0;
    repeat (8) @(posedge aclk);
    #1;
    arst_n = 1'b1;
    @(negedge aclk);
    assert (out_tvalid == '0) else report_mismatch("out_tvalid", 64'(out_tvalid), 64'd0);
    assert (rready) else report_mismatch("rready", 64'(rready), 64'd1);
    tick();
    // Isolated beats that each reach an idle channel
    restart_runs(8'd3);
    for (int i = 0; i < 8; i++) begin
      send_beat(merge_pkg::ch_id_t'(i), i == 5);
      wait_drain();
    end
    ready_gaps = 1'b1;
    restart_runs(8'd4);
    send_random(100);
    wait_drain();
    restart_runs(8'd0);  // Only rlast marks run ends
    send_random(60);
    wait_drain();
    // Channel 0 stalled with half the beats aimed at it
    ready_gaps = 1'b0;
    low_mark   = low_cycles;
    hold_ch0   = 1'b1;
    for (int i = 0; i < 40; i++) begin
      rnd = xorshift(rnd);
      send_beat((i % 2 == 0) ? 2'd0 : merge_pkg::ch_id_t'(1 + rnd % 3), 1'b0);
    end
    hold_ch0 = 1'b0;
    wait_drain();
    assert (low_cycles > low_mark) else begin
      other_errors++;
      $display("ERROR: rready never dropped while channel 0 was stalled");
    end
    assert (other_taken > 0) else begin
      other_errors++;
      $display("ERROR: no other channel delivered while channel 0 was stalled");
    end
    finish_run();
  end

endmodule

// File: design/merge_frontend_top.sv
/*
  Read-side front end top: run tagger, presort pipeline
  and channel FIFO bank
*/
`timescale 1ns/100ps

module merge_frontend_top (
  input  logic                                     aclk,
  input  logic                                     arst_n,
  // Control
  input  logic                                     start,
  input  merge_pkg::run_cnt_t                      run_beats,
  // Read-data channel
  input  logic                                     rvalid,
  output logic                                     rready,
  input  merge_pkg::beat_t                         rdata,
  input  merge_pkg::ch_id_t                        rid,
  input  logic                                     rlast,
  // Per-channel output streams
  output logic [merge_pkg::NUM_CH-1:0]             out_tvalid,
  input  logic [merge_pkg::NUM_CH-1:0]             out_tready,
  output merge_pkg::beat_t [merge_pkg::NUM_CH-1:0] out_tdata,
  output logic [merge_pkg::NUM_CH-1:0]             out_tlast
);

  beat_if tag_beat ();   // Tagger to presort
  beat_if sort_beat ();  // Presort to FIFO bank

  ////////////////////
  // Run tagging
  ////////////////////
  run_tagger u_run_tagger (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .start     (start),
    .run_beats (run_beats),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .rid       (rid),
    .rlast     (rlast),
    .tag_out   (tag_beat.src)
  );

  ////////////////////
  // Presort
  ////////////////////
  beat_presort u_beat_presort (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .in_beat  (tag_beat.dst),
    .out_beat (sort_beat.src)
  );

  ////////////////////
  // Buffering
  ////////////////////
  // FIFO credit drives rready straight
  channel_fifo_bank u_channel_fifo_bank (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .in_beat    (sort_beat.dst),
    .out_tvalid (out_tvalid),
    .out_tready (out_tready),
    .out_tdata  (out_tdata),
    .out_tlast  (out_tlast),
    .space_ok   (rready)
  );

endmodule

// File: design/channel_fifo_bank.sv
/*
  Channel demultiplexer, four channel FIFOs and the credit
  check behind read-data ready
*/
`timescale 1ns/100ps

module channel_fifo_bank (
  input  logic                                     aclk,
  input  logic                                     arst_n,
  beat_if.dst                                      in_beat,
  output logic [merge_pkg::NUM_CH-1:0]             out_tvalid,
  input  logic [merge_pkg::NUM_CH-1:0]             out_tready,
  output merge_pkg::beat_t [merge_pkg::NUM_CH-1:0] out_tdata,
  output logic [merge_pkg::NUM_CH-1:0]             out_tlast,
  output logic                                     space_ok
);

  logic [merge_pkg::NUM_CH-1:0] ch_wr;
  merge_pkg::fifo_cnt_t         ch_count [merge_pkg::NUM_CH];

  ////////////////////
  // Per-channel buffers
  ////////////////////
  for (genvar ch = 0; ch < merge_pkg::NUM_CH; ch++) begin : g_ch
    assign ch_wr[ch] = in_beat.valid && (in_beat.id == merge_pkg::ch_id_t'(ch));

    stream_fifo u_stream_fifo (
      .aclk     (aclk),
      .arst_n   (arst_n),
      .wr_en    (ch_wr[ch]),
      .wr_data  (in_beat.data),
      .wr_last  (in_beat.last),
      .rd_valid (out_tvalid[ch]),
      .rd_ready (out_tready[ch]),
      .rd_data  (out_tdata[ch]),
      .rd_last  (out_tlast[ch]),
      .count    (ch_count[ch])
    );
  end

  ////////////////////
  // Credit check
  ////////////////////
  // Any FIFO past the threshold stops new beats, in-flight ones still fit
  always_comb begin
    space_ok = 1'b1;
    for (int i = 0; i < merge_pkg::NUM_CH; i++) begin
      if (ch_count[i] >
          merge_pkg::fifo_cnt_t'(merge_pkg::FIFO_DEPTH - merge_pkg::CREDIT_SLACK)) begin
        space_ok = 1'b0;
      end
    end
  end

endmodule

// File: design/stream_fifo.sv
/*
  Show-ahead synchronous FIFO for one channel, beat plus last bit
*/
`timescale 1ns/100ps

module stream_fifo (
  input  logic                 aclk,
  input  logic                 arst_n,
  input  logic                 wr_en,
  input  merge_pkg::beat_t     wr_data,
  input  logic                 wr_last,
  output logic                 rd_valid,
  input  logic                 rd_ready,
  output merge_pkg::beat_t     rd_data,
  output logic                 rd_last,
  output merge_pkg::fifo_cnt_t count
);

  merge_pkg::beat_t          mem_data [merge_pkg::FIFO_DEPTH];
  logic                      mem_last [merge_pkg::FIFO_DEPTH];
  logic [merge_pkg::PTR_W-1:0] wr_ptr;
  logic [merge_pkg::PTR_W-1:0] rd_ptr;
  merge_pkg::fifo_cnt_t      count_q;
  logic                      full;
  logic                      do_wr;
  logic                      do_rd;

  assign full     = (count_q == merge_pkg::fifo_cnt_t'(merge_pkg::FIFO_DEPTH));
  assign do_wr    = wr_en & ~full;
  assign rd_valid = (count_q != '0);
  assign do_rd    = rd_valid & rd_ready;

  always_ff @(posedge aclk) begin
    if (do_wr) begin
      mem_data[wr_ptr] <= wr_data;
      mem_last[wr_ptr] <= wr_last;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Idle or both
      endcase
    end
  end

  // Head entry shown while not empty
  assign rd_data = mem_data[rd_ptr];
  assign rd_last = mem_last[rd_ptr];
  assign count   = count_q;

endmodule

// File: design/beat_presort.sv
/*
  Three-layer pipelined sorting network for the four keys of
  a beat, with id, mark and valid carried in step
*/
`timescale 1ns/100ps

module beat_presort (
  input  logic aclk,
  input  logic arst_n,
  beat_if.dst  in_beat,
  beat_if.src  out_beat
);

  merge_pkg::key_t   in_key [merge_pkg::LANES];
  merge_pkg::key_t   l1_key [merge_pkg::LANES];
  merge_pkg::key_t   l2_key [merge_pkg::LANES];
  merge_pkg::key_t   l3_key [merge_pkg::LANES];
  merge_pkg::beat_t  sorted_data;

  logic [merge_pkg::SORT_STAGES-1:0] vld_pipe;
  logic [merge_pkg::SORT_STAGES-1:0] last_pipe;
  merge_pkg::ch_id_t                 id_pipe [merge_pkg::SORT_STAGES];

  function automatic merge_pkg::key_t key_min(merge_pkg::key_t a, merge_pkg::key_t b);
    return (a < b) ? a : b;
  endfunction

  function automatic merge_pkg::key_t key_max(merge_pkg::key_t a, merge_pkg::key_t b);
    return (a < b) ? b : a;
  endfunction

  always_comb begin
    for (int i = 0; i < merge_pkg::LANES; i++) begin
      in_key[i] = in_beat.data[i*merge_pkg::KEY_W +: merge_pkg::KEY_W];
    end
  end

  ////////////////////
  // Compare-exchange layers
  ////////////////////
  always_ff @(posedge aclk) begin
    // Layer 1 sorts the pairs (0,1) and (2,3)
    l1_key[0] <= key_min(in_key[0], in_key[1]);
    l1_key[1] <= key_max(in_key[0], in_key[1]);
    l1_key[2] <= key_min(in_key[2], in_key[3]);
    l1_key[3] <= key_max(in_key[2], in_key[3]);
    // Layer 2 settles global min and max
    l2_key[0] <= key_min(l1_key[0], l1_key[2]);
    l2_key[2] <= key_max(l1_key[0], l1_key[2]);
    l2_key[1] <= key_min(l1_key[1], l1_key[3]);
    l2_key[3] <= key_max(l1_key[1], l1_key[3]);
    // Layer 3 orders the middle pair
    l3_key[0] <= l2_key[0];
    l3_key[1] <= key_min(l2_key[1], l2_key[2]);
    l3_key[2] <= key_max(l2_key[1], l2_key[2]);
    l3_key[3] <= l2_key[3];
  end

  ////////////////////
  // Side-band pipe
  ////////////////////
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[merge_pkg::SORT_STAGES-2:0], in_beat.valid};
    end
  end

  always_ff @(posedge aclk) begin
    last_pipe  <= {last_pipe[merge_pkg::SORT_STAGES-2:0], in_beat.last};
    id_pipe[0] <= in_beat.id;
    for (int s = 1; s < merge_pkg::SORT_STAGES; s++) begin
      id_pipe[s] <= id_pipe[s-1];
    end
  end

  always_comb begin
    for (int i = 0; i < merge_pkg::LANES; i++) begin
      sorted_data[i*merge_pkg::KEY_W +: merge_pkg::KEY_W] = l3_key[i];  // Smallest in lane 0
    end
  end

  assign out_beat.valid = vld_pipe[merge_pkg::SORT_STAGES-1];
  assign out_beat.data  = sorted_data;
  assign out_beat.id    = id_pipe[merge_pkg::SORT_STAGES-1];
  assign out_beat.last  = last_pipe[merge_pkg::SORT_STAGES-1];

endmodule

// File: design/run_tagger.sv
/*
  Per-channel run counters and the input register that
  attaches the run-end mark to each accepted beat
*/
`timescale 1ns/100ps

module run_tagger (
  input  logic                aclk,
  input  logic                arst_n,
  input  logic                start,
  input  merge_pkg::run_cnt_t run_beats,
  input  logic                rvalid,
  input  logic                rready,
  input  merge_pkg::beat_t    rdata,
  input  merge_pkg::ch_id_t   rid,
  input  logic                rlast,
  beat_if.src                 tag_out
);

  logic                accept;
  logic                run_end;
  merge_pkg::run_cnt_t cur_cnt;
  merge_pkg::run_cnt_t run_cnt [merge_pkg::NUM_CH];

  assign accept = rvalid & rready;

  // A start pulse restarts the count for a beat on the same cycle too
  assign cur_cnt = start ? '0 : run_cnt[rid];

  // run_beats of 0 leaves run ends to rlast alone
  assign run_end = (run_beats != '0) &&
                   (cur_cnt == merge_pkg::run_cnt_t'(run_beats - 1'b1));

  ////////////////////
  // Run counters
  ////////////////////
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < merge_pkg::NUM_CH; i++) begin
        run_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < merge_pkg::NUM_CH; i++) begin
        if (accept && (rid == merge_pkg::ch_id_t'(i))) begin
          run_cnt[i] <= run_end ? '0 : cur_cnt + 1'b1;  // Wrap at run length
        end else if (start) begin
          run_cnt[i] <= '0;
        end
      end
    end
  end

  ////////////////////
  // Beat register
  ////////////////////
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      tag_out.valid <= 1'b0;
    end else begin
      tag_out.valid <= accept;
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      tag_out.data <= rdata;
      tag_out.id   <= rid;
      tag_out.last <= rlast | run_end;  // Burst end or full run
    end
  end

endmodule

// File: design/beat_if.sv
/*
  One tagged beat moving between pipeline stages
*/
`timescale 1ns/100ps

interface beat_if;

  logic               valid;  // No ready, pipeline never stalls
  merge_pkg::beat_t   data;
  merge_pkg::ch_id_t  id;
  logic               last;   // Run-end mark

  modport src (
    output valid,
    output data,
    output id,
    output last
  );

  modport dst (
    input valid,
    input data,
    input id,
    input last
  );

endinterface

// File: design/merge_pkg.sv
/*
  Widths, counts and vector types shared by the read-side
  front end of the merge sorter
*/
package merge_pkg;

  ////////////////////
  // Beat geometry
  ////////////////////
  localparam int NUM_CH = 4;             // Read channels
  localparam int LANES  = 4;             // Keys per beat
  localparam int KEY_W  = 16;
  localparam int BEAT_W = LANES * KEY_W; // 64 bits, lane 0 low
  localparam int ID_W   = 2;
  localparam int RUN_W  = 8;

  ////////////////////
  // Buffering and flow control
  ////////////////////
  localparam int FIFO_DEPTH  = 16;
  localparam int PTR_W       = $clog2(FIFO_DEPTH);
  localparam int CNT_W       = PTR_W + 1;     // Holds 0 .. FIFO_DEPTH
  localparam int SORT_STAGES = 3;

  // Entries that must stay free while rready is high:
  // presort stages, tagger register and the beat being accepted
  localparam int CREDIT_SLACK = SORT_STAGES + 2;

  ////////////////////
  // Vector types
  ////////////////////
  typedef logic [KEY_W-1:0]  key_t;
  typedef logic [BEAT_W-1:0] beat_t;
  typedef logic [ID_W-1:0]   ch_id_t;
  typedef logic [RUN_W-1:0]  run_cnt_t;
  typedef logic [CNT_W-1:0]  fifo_cnt_t;

endpackage
